/* arp_cache.sv */
//##############################
// Dynamic IP to MAC cache
//   One-cycle parallel query
//   Search-then-replace write FSM
//   One LRU bit per entry
//   Clear sweep, also after reset
//##############################

`timescale 1ns/10ps

module arp_cache
    import arp_pkg::*;
#(
    parameter int CACHE_ADDR_WIDTH = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      query_valid,
    input  ip_addr_t  query_ip,
    output logic      query_resp_valid,
    output logic      query_hit,
    output mac_addr_t query_mac,
    input  logic      write_valid,
    input  ip_addr_t  write_ip,
    input  mac_addr_t write_mac,
    output logic      write_in_progress,
    output logic      write_complete,
    input  logic      clear_cache
);

    localparam int ENTRIES = 2 ** CACHE_ADDR_WIDTH;

    ip_addr_t                    ip_mem  [ENTRIES];  // Zero means empty
    mac_addr_t                   mac_mem [ENTRIES];
    logic [ENTRIES-1:0]          lru_bit;            // Set on query hit
    logic [ENTRIES-1:0]          hit_vec;
    mac_addr_t                   hit_mac;
    cache_state_e                state;
    ip_addr_t                    write_ip_reg;
    mac_addr_t                   write_mac_reg;
    logic [CACHE_ADDR_WIDTH-1:0] search_addr;
    logic [CACHE_ADDR_WIDTH-1:0] write_ptr;          // Round-robin victim pointer
    logic [CACHE_ADDR_WIDTH-1:0] clear_addr;
    logic                        clearing;
    logic                        write_accept;
    logic                        search_hit;
    logic                        place;
    logic                        clear_start;

    assign write_in_progress = (state != CACHE_IDLE) || clearing;  // Sweep counts as busy
    assign write_accept = write_valid && !write_in_progress;
    assign search_hit   = (state == CACHE_SEARCH) && (ip_mem[search_addr] == write_ip_reg);
    assign place        = (state == CACHE_NOT_FOUND) && !lru_bit[write_ptr];
    assign clear_start  = clear_cache && !clearing;

    // Parallel compare over all entries, IP zero never hits
    always_comb begin
        hit_vec = '0;
        hit_mac = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (ip_mem[i] == query_ip && query_ip != '0) begin
                hit_vec[i] = 1'b1;
                hit_mac    = mac_mem[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            query_resp_valid <= 1'b0;
            query_hit        <= 1'b0;
            write_complete   <= 1'b0;
            state            <= CACHE_IDLE;
            search_addr      <= '0;
            write_ptr        <= '0;
            clear_addr       <= '0;
            clearing         <= 1'b1;                 // Sweep the table out of reset
            lru_bit          <= '0;
        end else begin
            query_resp_valid <= query_valid;
            query_hit        <= query_valid && (|hit_vec);
            write_complete   <= 1'b0;
            // Age out all bits once every entry was used, then mark new hits
            lru_bit <= ((&lru_bit) ? '0 : lru_bit) | (query_valid ? hit_vec : '0);

            case (state)
                CACHE_IDLE: begin
                    search_addr <= '0;
                    if (write_accept) begin
                        state <= CACHE_SEARCH;
                    end
                end
                CACHE_SEARCH: begin
                    search_addr <= search_addr + 1'b1;
                    if (search_hit) begin             // Existing IP, MAC overwritten
                        state          <= CACHE_IDLE;
                        write_complete <= 1'b1;
                    end else if (&search_addr) begin  // Walked every entry
                        state <= CACHE_NOT_FOUND;
                    end
                end
                CACHE_NOT_FOUND: begin
                    write_ptr <= write_ptr + 1'b1;
                    if (place) begin
                        state          <= CACHE_IDLE;
                        write_complete <= 1'b1;
                    end
                end
                default: state <= CACHE_IDLE;
            endcase

            if (clear_start) begin
                clearing   <= 1'b1;
                clear_addr <= '0;
                lru_bit    <= '0;
            end else if (clearing) begin
                clear_addr <= clear_addr + 1'b1;
                clearing   <= ~&clear_addr;           // Done after the last entry
            end
        end
    end

    // Table storage and payload registers
    always_ff @(posedge clk) begin
        if (write_accept) begin
            write_ip_reg  <= write_ip;
            write_mac_reg <= write_mac;
        end
        if (query_valid) begin
            query_mac <= hit_mac;
        end
        if (clearing) begin                           // Sweep wins over a write
            ip_mem[clear_addr]  <= '0;
            mac_mem[clear_addr] <= '0;
        end else if (place) begin
            ip_mem[write_ptr]  <= write_ip_reg;
            mac_mem[write_ptr] <= write_mac_reg;
        end else if (search_hit) begin
            mac_mem[search_addr] <= write_mac_reg;
        end
    end

    // Ctrl must hold off writes until the FSM and the sweep are idle
    assert property (@(posedge clk) disable iff (rst)
        !(write_valid && write_in_progress));

endmodule

/* arp_lookup_ctrl.sv */
//##############################
// Lookup and write control
//   Query and response handshakes
//   Write dispatch by opcode
//   Priority merge of table results
//##############################

`timescale 1ns/10ps

module arp_lookup_ctrl
    import arp_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          query_valid,
    output logic          query_ready,
    input  ip_addr_t      query_ip,
    output logic          resp_valid,
    input  logic          resp_ready,
    output arp_status_e   resp_status,
    output mac_addr_t     resp_mac,
    input  logic          write_valid,
    output logic          write_ready,
    input  arp_write_op_e write_op,
    input  ip_addr_t      write_ip,
    input  mac_addr_t     write_mac,
    output logic          write_done,
    output logic          write_error,
    output logic          cache_query_valid,
    output logic          static_query_valid,
    output ip_addr_t      lookup_ip,
    input  logic          cache_resp_valid,
    input  logic          cache_hit,
    input  mac_addr_t     cache_mac,
    input  logic          static_resp_valid,
    input  logic          static_hit,
    input  mac_addr_t     static_mac,
    output logic          cache_write_valid,
    output logic          static_write_valid,
    output ip_addr_t      table_write_ip,
    output mac_addr_t     table_write_mac,
    input  logic          cache_busy,
    input  logic          cache_write_complete,
    input  logic          static_write_done,
    input  logic          static_write_full
);

    logic        active;          // Low only until the first edge after reset
    logic        in_flight;
    logic        table_query;
    logic        write_busy;
    logic        cache_write_pending;
    logic        query_fire;
    logic        write_fire;
    logic        resp_load;
    arp_status_e merge_status;
    mac_addr_t   merge_mac;

    assign query_ready        = active && !in_flight && (!resp_valid || resp_ready);
    assign query_fire         = query_valid && query_ready;
    assign write_ready        = !write_busy && !cache_busy;      // Covers the clear sweep
    assign write_fire         = write_valid && write_ready;
    assign cache_write_valid  = cache_write_pending && !cache_busy;
    assign cache_query_valid  = table_query;                    // Both tables see one strobe
    assign static_query_valid = table_query;
    assign resp_load          = cache_resp_valid || static_resp_valid;

    always_comb begin
        if (static_resp_valid && static_hit) begin
            merge_status = ARP_HIT_STATIC;
            merge_mac    = static_mac;
        end else if (cache_resp_valid && cache_hit) begin
            merge_status = ARP_HIT_DYNAMIC;
            merge_mac    = cache_mac;
        end else begin
            merge_status = ARP_MISS;
            merge_mac    = '0;                // Miss reports a zero MAC
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active              <= 1'b0;
            in_flight           <= 1'b0;
            table_query         <= 1'b0;
            resp_valid          <= 1'b0;
            resp_status         <= ARP_MISS;
            write_busy          <= 1'b0;
            cache_write_pending <= 1'b0;
            static_write_valid  <= 1'b0;
            write_done          <= 1'b0;
            write_error         <= 1'b0;
        end else begin
            active      <= 1'b1;
            table_query <= query_fire;
            if (query_fire) begin
                in_flight <= 1'b1;
            end else if (resp_load) begin
                in_flight <= 1'b0;
            end
            // Response slot is always free when results land
            if (resp_load) begin
                resp_valid  <= 1'b1;
                resp_status <= merge_status;
            end else if (resp_ready) begin
                resp_valid <= 1'b0;
            end
            static_write_valid <= write_fire && (write_op == ARP_OP_STATIC);
            if (write_fire && write_op == ARP_OP_DYNAMIC) begin
                cache_write_pending <= 1'b1;
            end else if (cache_write_valid) begin
                cache_write_pending <= 1'b0;
            end
            write_done  <= cache_write_complete || static_write_done;
            write_error <= static_write_done && static_write_full;
            if (write_fire) begin
                write_busy <= 1'b1;
            end else if (cache_write_complete || static_write_done) begin
                write_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (query_fire) begin
            lookup_ip <= query_ip;
        end
        if (write_fire) begin
            table_write_ip  <= write_ip;
            table_write_mac <= write_mac;
        end
        if (resp_load) begin
            resp_mac <= merge_mac;
        end
    end

    // Held response must not change under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=>
            resp_valid && $stable(resp_status) && $stable(resp_mac));

endmodule

/* arp_pkg.sv */
//##############################
// Shared types for the ARP resolver
//   IPv4 and MAC address types
//   Write target opcode
//   Lookup status codes
//   Dynamic cache write states
//##############################

package arp_pkg;

    typedef logic [31:0] ip_addr_t;   // IPv4 address, zero marks an empty slot
    typedef logic [47:0] mac_addr_t;  // Ethernet MAC address

    // Which table a write command goes to
    typedef enum logic {
        ARP_OP_DYNAMIC = 1'b0,        // Learned entry, into the LRU cache
        ARP_OP_STATIC  = 1'b1         // Configured entry, never ages out
    } arp_write_op_e;

    // Merged lookup result, static beats dynamic beats miss
    typedef enum logic [1:0] {
        ARP_HIT_STATIC  = 2'd0,
        ARP_HIT_DYNAMIC = 2'd1,
        ARP_MISS        = 2'd2
    } arp_status_e;

    // Dynamic cache write FSM
    typedef enum logic [1:0] {
        CACHE_IDLE      = 2'd0,       // Waiting for a write
        CACHE_SEARCH    = 2'd1,       // Walking entries for a matching IP
        CACHE_NOT_FOUND = 2'd2        // Looking for a slot with LRU bit clear
    } cache_state_e;

endpackage

/* arp_resolver_tb.sv */
//##############################
// Testbench for the ARP resolver
//   Clock, reset and watchdog
//   Stimulus table of steps
//   Write, query and clear drivers
//   Response and write compares
//##############################

`timescale 1ns/10ps

module arp_resolver_tb
    import arp_pkg::*;
();

    localparam int unsigned TB_SEED       = 32'ha1ea_19c5;
    localparam int          CLK_HALF      = 50;        // 100 ns period
    localparam int          RESET_CYCLES  = 8;
    localparam int          STEP_CYCLES   = 64;        // Budget per step
    localparam int          SETTLE_CYCLES = 200;       // Reset, sweep and margin

    localparam ip_addr_t  IP_D1      = 32'h0a00_0001;  // Dynamic entries
    localparam ip_addr_t  IP_D2      = 32'h0a00_0002;
    localparam ip_addr_t  IP_D3      = 32'h0a00_0003;
    localparam ip_addr_t  IP_D4      = 32'h0a00_0004;
    localparam ip_addr_t  IP_S2      = 32'hc0a8_0002;  // Static only
    localparam ip_addr_t  IP_S3      = 32'hc0a8_0003;
    localparam ip_addr_t  IP_S4      = 32'hc0a8_0004;
    localparam ip_addr_t  IP_S5      = 32'hc0a8_0005;  // One past a full table
    localparam ip_addr_t  IP_UNKNOWN = 32'h0a00_00ff;
    localparam mac_addr_t MAC_D1     = 48'h0200_0000_0001;
    localparam mac_addr_t MAC_D2     = 48'h0200_0000_0002;
    localparam mac_addr_t MAC_D3     = 48'h0200_0000_0003;
    localparam mac_addr_t MAC_D4     = 48'h0200_0000_0004;
    localparam mac_addr_t MAC_D2_NEW = 48'h0200_0000_0022;
    localparam mac_addr_t MAC_S1     = 48'h0e00_0000_0001;  // Static copy of IP_D1
    localparam mac_addr_t MAC_S2     = 48'h0e00_0000_0002;
    localparam mac_addr_t MAC_S3     = 48'h0e00_0000_0003;
    localparam mac_addr_t MAC_S4     = 48'h0e00_0000_0004;
    localparam mac_addr_t MAC_S5     = 48'h0e00_0000_0005;
    localparam mac_addr_t MAC_S2_NEW = 48'h0e00_0000_0022;

    typedef enum logic [1:0] {
        STEP_WRITE,
        STEP_QUERY,
        STEP_CLEAR
    } step_kind_e;

    logic          clk;
    logic          rst;
    logic          clear_cache;
    logic          query_valid;
    logic          query_ready;
    ip_addr_t      query_ip;
    logic          resp_valid;
    logic          resp_ready;
    arp_status_e   resp_status;
    mac_addr_t     resp_mac;
    logic          write_valid;
    logic          write_ready;
    arp_write_op_e write_op;
    ip_addr_t      write_ip;
    mac_addr_t     write_mac;
    logic          write_done;
    logic          write_error;

    step_kind_e    kind_q[$];      // Stimulus table, one entry per step
    arp_write_op_e op_q[$];
    ip_addr_t      ip_q[$];
    mac_addr_t     mac_q[$];
    arp_status_e   exp_status_q[$];
    mac_addr_t     exp_mac_q[$];
    logic          exp_err_q[$];

    int pass_count     = 0;
    int fail_count     = 0;
    int query_steps    = 0;
    int accepted_count = 0;        // Query handshakes seen on the bus
    int resp_count     = 0;        // Response handshakes seen on the bus
    int cycle_count    = 0;
    int timeout_cycles = 0;

    arp_resolver_top UUT (
        .clk         (clk),
        .rst         (rst),
        .clear_cache (clear_cache),
        .query_valid (query_valid),
        .query_ready (query_ready),
        .query_ip    (query_ip),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_status (resp_status),
        .resp_mac    (resp_mac),
        .write_valid (write_valid),
        .write_ready (write_ready),
        .write_op    (write_op),
        .write_ip    (write_ip),
        .write_mac   (write_mac),
        .write_done  (write_done),
        .write_error (write_error)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Handshake counters, sampled before the DUT updates
    always @(posedge clk) begin
        if (!rst && query_valid && query_ready) accepted_count++;
        if (!rst && resp_valid && resp_ready) resp_count++;
    end

    initial begin : watchdog
        cache_state_e cache_state;
        do begin
            @(posedge clk);
            cycle_count++;
        end while (cycle_count < timeout_cycles);
        cache_state = UUT.u_cache.state;           // Where the cache FSM got stuck
        $display("ERROR: timeout after %0d cycles, DUT stopped answering (cache in %s)",
                 cycle_count, cache_state.name());
        $display("Testbench failed");
        $finish;
    end

    function automatic void add_step(input step_kind_e kind, input arp_write_op_e op,
                                     input ip_addr_t ip, input mac_addr_t mac,
                                     input arp_status_e exp_status, input mac_addr_t exp_mac,
                                     input logic exp_err);
        kind_q.push_back(kind);
        op_q.push_back(op);
        ip_q.push_back(ip);
        mac_q.push_back(mac);
        exp_status_q.push_back(exp_status);
        exp_mac_q.push_back(exp_mac);
        exp_err_q.push_back(exp_err);
        if (kind == STEP_QUERY) query_steps++;
    endfunction

    task automatic build_table;
        // Learn four entries, the whole cache
        add_step(STEP_WRITE, ARP_OP_DYNAMIC, IP_D1, MAC_D1, ARP_MISS, '0, 1'b0);
        add_step(STEP_WRITE, ARP_OP_DYNAMIC, IP_D2, MAC_D2, ARP_MISS, '0, 1'b0);
        add_step(STEP_WRITE, ARP_OP_DYNAMIC, IP_D3, MAC_D3, ARP_MISS, '0, 1'b0);
        add_step(STEP_WRITE, ARP_OP_DYNAMIC, IP_D4, MAC_D4, ARP_MISS, '0, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_D1, '0, ARP_HIT_DYNAMIC, MAC_D1, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_D2, '0, ARP_HIT_DYNAMIC, MAC_D2, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_D3, '0, ARP_HIT_DYNAMIC, MAC_D3, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_D4, '0, ARP_HIT_DYNAMIC, MAC_D4, 1'b0);
        // Overwrite, neighbours untouched
        add_step(STEP_WRITE, ARP_OP_DYNAMIC, IP_D2, MAC_D2_NEW, ARP_MISS, '0, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_D2, '0, ARP_HIT_DYNAMIC, MAC_D2_NEW, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_D1, '0, ARP_HIT_DYNAMIC, MAC_D1, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_D3, '0, ARP_HIT_DYNAMIC, MAC_D3, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_D4, '0, ARP_HIT_DYNAMIC, MAC_D4, 1'b0);
        // Static beats dynamic, unknown misses
        add_step(STEP_WRITE, ARP_OP_STATIC, IP_D1, MAC_S1, ARP_MISS, '0, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_D1, '0, ARP_HIT_STATIC, MAC_S1, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_UNKNOWN, '0, ARP_MISS, '0, 1'b0);
        // Fill the static table, fifth entry refused
        add_step(STEP_WRITE, ARP_OP_STATIC, IP_S2, MAC_S2, ARP_MISS, '0, 1'b0);
        add_step(STEP_WRITE, ARP_OP_STATIC, IP_S3, MAC_S3, ARP_MISS, '0, 1'b0);
        add_step(STEP_WRITE, ARP_OP_STATIC, IP_S4, MAC_S4, ARP_MISS, '0, 1'b0);
        add_step(STEP_WRITE, ARP_OP_STATIC, IP_S5, MAC_S5, ARP_MISS, '0, 1'b1);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_S5, '0, ARP_MISS, '0, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_S2, '0, ARP_HIT_STATIC, MAC_S2, 1'b0);
        // Overwrite of a used static slot still works when full
        add_step(STEP_WRITE, ARP_OP_STATIC, IP_S2, MAC_S2_NEW, ARP_MISS, '0, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_S2, '0, ARP_HIT_STATIC, MAC_S2_NEW, 1'b0);
        // Clear drops learned entries only
        add_step(STEP_CLEAR, ARP_OP_DYNAMIC, '0, '0, ARP_MISS, '0, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_D2, '0, ARP_MISS, '0, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_D3, '0, ARP_MISS, '0, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_D1, '0, ARP_HIT_STATIC, MAC_S1, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_S3, '0, ARP_HIT_STATIC, MAC_S3, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_S4, '0, ARP_HIT_STATIC, MAC_S4, 1'b0);
        // Cache learns again after the sweep
        add_step(STEP_WRITE, ARP_OP_DYNAMIC, IP_D3, MAC_D3, ARP_MISS, '0, 1'b0);
        add_step(STEP_QUERY, ARP_OP_DYNAMIC, IP_D3, '0, ARP_HIT_DYNAMIC, MAC_D3, 1'b0);
    endtask

    task automatic flag_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        fail_count++;
    endtask

    task automatic check_resp(input int step, input ip_addr_t ip,
                              input arp_status_e exp_status, input arp_status_e got_status,
                              input mac_addr_t exp_mac, input mac_addr_t got_mac);
        if (got_status !== exp_status || got_mac !== exp_mac) begin
            $display("mismatch at %0t: step %0d query %h expected %s %h, got %s %h",
                     $time, step, ip, exp_status.name(), exp_mac, got_status.name(), got_mac);
            fail_count++;
        end else begin
            $display("step %0d query %h: %s %h ok", step, ip, got_status.name(), got_mac);
            pass_count++;
        end
    endtask

    task automatic check_write(input int step, input ip_addr_t ip,
                               input logic exp_err, input logic got_err);
        if (got_err !== exp_err) begin
            $display("mismatch at %0t: step %0d write %h expected error %0b, got %0b",
                     $time, step, ip, exp_err, got_err);
            fail_count++;
        end else begin
            $display("step %0d write %h: error %0b ok", step, ip, got_err);
            pass_count++;
        end
    endtask

    // Called on a falling edge, returns on the falling edge that shows write_done
    task automatic issue_write(input int step, input arp_write_op_e op, input ip_addr_t ip,
                               input mac_addr_t mac, input logic exp_err);
        write_op    = op;
        write_ip    = ip;
        write_mac   = mac;
        write_valid = 1'b1;
        while (!write_ready) @(negedge clk);
        @(negedge clk);                            // Taken on the edge just passed
        write_valid = 1'b0;
        while (!write_done) @(negedge clk);
        check_write(step, ip, exp_err, write_error);
    endtask

    task automatic lookup_query(input int step, input ip_addr_t ip,
                                input arp_status_e exp_status, input mac_addr_t exp_mac);
        int          hold;
        int          latency;
        arp_status_e held_status;
        mac_addr_t   held_mac;
        hold        = int'($urandom % 4);          // 0 to 3 cycles of back-pressure
        latency     = 0;
        resp_ready  = 1'b0;
        query_ip    = ip;
        query_valid = 1'b1;
        while (!query_ready) @(negedge clk);
        @(negedge clk);
        query_valid = 1'b0;
        while (!resp_valid) begin
            @(negedge clk);
            latency++;
        end
        if (latency != 2) begin
            flag_error($sformatf("step %0d response came %0d cycles after accept, not 2",
                                 step, latency));
        end
        held_status = resp_status;
        held_mac    = resp_mac;
        if (query_ready) begin
            flag_error($sformatf("step %0d query_ready high under back-pressure", step));
        end
        repeat (hold) begin
            @(negedge clk);
            if (!resp_valid || resp_status !== held_status || resp_mac !== held_mac) begin
                flag_error($sformatf("step %0d response changed while resp_ready was low", step));
            end
            if (query_ready) begin
                flag_error($sformatf("step %0d query_ready high under back-pressure", step));
            end
        end
        resp_ready = 1'b1;
        @(negedge clk);                            // Response taken on the edge just passed
        if (resp_valid) flag_error($sformatf("step %0d response repeated after accept", step));
        check_resp(step, ip, exp_status, held_status, exp_mac, held_mac);
    endtask

    task automatic clear_dynamic(input int step);
        clear_cache = 1'b1;
        @(negedge clk);
        clear_cache = 1'b0;
        if (write_ready) begin
            flag_error($sformatf("step %0d write_ready stayed high during the clear sweep", step));
        end else begin
            pass_count++;
        end
        while (!write_ready) @(negedge clk);
        $display("step %0d clear: sweep finished", step);
    endtask

    initial begin : stimulus
        rst         = 1'b1;
        clear_cache = 1'b0;
        query_valid = 1'b0;
        query_ip    = '0;
        resp_ready  = 1'b1;
        write_valid = 1'b0;
        write_op    = ARP_OP_DYNAMIC;
        write_ip    = '0;
        write_mac   = '0;
        void'($urandom(TB_SEED));
        build_table();
        timeout_cycles = kind_q.size() * STEP_CYCLES + SETTLE_CYCLES;

        repeat (RESET_CYCLES) @(negedge clk);
        if (resp_valid || write_done || write_error || query_ready || write_ready) begin
            flag_error("outputs not idle during reset");
        end else begin
            $display("reset: outputs idle ok");
            pass_count++;
        end
        rst = 1'b0;
        while (!write_ready) @(negedge clk);       // Sweep after reset

        foreach (kind_q[i]) begin
            @(negedge clk);
            case (kind_q[i])
                STEP_WRITE: issue_write(i, op_q[i], ip_q[i], mac_q[i], exp_err_q[i]);
                STEP_QUERY: lookup_query(i, ip_q[i], exp_status_q[i], exp_mac_q[i]);
                default:    clear_dynamic(i);
            endcase
        end

        @(negedge clk);
        if (accepted_count != query_steps || resp_count != query_steps) begin
            flag_error($sformatf("%0d queries, %0d accepted, %0d responses",
                                 query_steps, accepted_count, resp_count));
        end
        $display("Done: %0d checks passed, %0d checks failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* arp_resolver_top.sv */
//##############################
// ARP next-hop resolver top level
//   Lookup control, dynamic cache
//   and static table wiring
//##############################

`timescale 1ns/10ps

module arp_resolver_top
    import arp_pkg::*;
#(
    parameter int CACHE_ADDR_WIDTH = 2,
    parameter int STATIC_ENTRIES   = 4
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          clear_cache,
    input  logic          query_valid,
    output logic          query_ready,
    input  ip_addr_t      query_ip,
    output logic          resp_valid,
    input  logic          resp_ready,
    output arp_status_e   resp_status,
    output mac_addr_t     resp_mac,
    input  logic          write_valid,
    output logic          write_ready,
    input  arp_write_op_e write_op,
    input  ip_addr_t      write_ip,
    input  mac_addr_t     write_mac,
    output logic          write_done,
    output logic          write_error
);

    logic      cache_query_valid;
    logic      static_query_valid;
    ip_addr_t  lookup_ip;          // Shared by both tables
    logic      cache_resp_valid;
    logic      cache_hit;
    mac_addr_t cache_mac;
    logic      static_resp_valid;
    logic      static_hit;
    mac_addr_t static_mac;
    logic      cache_write_valid;
    logic      static_write_valid;
    ip_addr_t  table_write_ip;
    mac_addr_t table_write_mac;
    logic      cache_busy;
    logic      cache_write_complete;
    logic      static_write_done;
    logic      static_write_full;

    arp_lookup_ctrl u_ctrl (
        .clk                  (clk),
        .rst                  (rst),
        .query_valid          (query_valid),
        .query_ready          (query_ready),
        .query_ip             (query_ip),
        .resp_valid           (resp_valid),
        .resp_ready           (resp_ready),
        .resp_status          (resp_status),
        .resp_mac             (resp_mac),
        .write_valid          (write_valid),
        .write_ready          (write_ready),
        .write_op             (write_op),
        .write_ip             (write_ip),
        .write_mac            (write_mac),
        .write_done           (write_done),
        .write_error          (write_error),
        .cache_query_valid    (cache_query_valid),
        .static_query_valid   (static_query_valid),
        .lookup_ip            (lookup_ip),
        .cache_resp_valid     (cache_resp_valid),
        .cache_hit            (cache_hit),
        .cache_mac            (cache_mac),
        .static_resp_valid    (static_resp_valid),
        .static_hit           (static_hit),
        .static_mac           (static_mac),
        .cache_write_valid    (cache_write_valid),
        .static_write_valid   (static_write_valid),
        .table_write_ip       (table_write_ip),
        .table_write_mac      (table_write_mac),
        .cache_busy           (cache_busy),
        .cache_write_complete (cache_write_complete),
        .static_write_done    (static_write_done),
        .static_write_full    (static_write_full)
    );

    arp_cache #(
        .CACHE_ADDR_WIDTH (CACHE_ADDR_WIDTH)
    ) u_cache (
        .clk               (clk),
        .rst               (rst),
        .query_valid       (cache_query_valid),
        .query_ip          (lookup_ip),
        .query_resp_valid  (cache_resp_valid),
        .query_hit         (cache_hit),
        .query_mac         (cache_mac),
        .write_valid       (cache_write_valid),
        .write_ip          (table_write_ip),
        .write_mac         (table_write_mac),
        .write_in_progress (cache_busy),
        .write_complete    (cache_write_complete),
        .clear_cache       (clear_cache)
    );

    arp_static_table #(
        .STATIC_ENTRIES (STATIC_ENTRIES)
    ) u_static (
        .clk              (clk),
        .rst              (rst),
        .query_valid      (static_query_valid),
        .query_ip         (lookup_ip),
        .query_resp_valid (static_resp_valid),
        .query_hit        (static_hit),
        .query_mac        (static_mac),
        .write_valid      (static_write_valid),
        .write_ip         (table_write_ip),
        .write_mac        (table_write_mac),
        .write_done       (static_write_done),
        .write_full       (static_write_full)
    );

endmodule

/* arp_static_table.sv */
//##############################
// Configured IP to MAC table
//   One-cycle parallel query
//   One-cycle write, lowest free slot
//   Full report when no slot is free
//##############################

`timescale 1ns/10ps

module arp_static_table
    import arp_pkg::*;
#(
    parameter int STATIC_ENTRIES = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      query_valid,
    input  ip_addr_t  query_ip,
    output logic      query_resp_valid,
    output logic      query_hit,
    output mac_addr_t query_mac,
    input  logic      write_valid,
    input  ip_addr_t  write_ip,
    input  mac_addr_t write_mac,
    output logic      write_done,
    output logic      write_full
);

    localparam int IDX_W = (STATIC_ENTRIES > 1) ? $clog2(STATIC_ENTRIES) : 1;

    ip_addr_t                ip_mem  [STATIC_ENTRIES];
    mac_addr_t               mac_mem [STATIC_ENTRIES];
    logic [STATIC_ENTRIES-1:0] used;                   // Slot holds a valid entry
    logic                    match_found;
    logic                    free_found;
    logic [IDX_W-1:0]        match_idx;
    logic [IDX_W-1:0]        free_idx;
    logic [IDX_W-1:0]        slot;
    logic                    store;
    logic                    hit_any;
    mac_addr_t               hit_mac;

    // Scan downwards so the lowest free slot is the one kept
    always_comb begin
        match_found = 1'b0;
        free_found  = 1'b0;
        match_idx   = '0;
        free_idx    = '0;
        hit_any     = 1'b0;
        hit_mac     = '0;
        for (int i = STATIC_ENTRIES - 1; i >= 0; i--) begin
            if (used[i] && ip_mem[i] == write_ip) begin
                match_found = 1'b1;
                match_idx   = IDX_W'(i);
            end
            if (!used[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
            if (used[i] && ip_mem[i] == query_ip) begin
                hit_any = 1'b1;
                hit_mac = mac_mem[i];
            end
        end
    end

    assign slot  = match_found ? match_idx : free_idx;  // Overwrite beats a new slot
    assign store = write_valid && (match_found || free_found);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            query_resp_valid <= 1'b0;
            query_hit        <= 1'b0;
            write_done       <= 1'b0;
            write_full       <= 1'b0;
            used             <= '0;
        end else begin
            query_resp_valid <= query_valid;
            query_hit        <= query_valid && hit_any;
            write_done       <= write_valid;
            write_full       <= write_valid && !store;  // Table untouched when full
            if (store) begin
                used[slot] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            ip_mem[slot]  <= write_ip;
            mac_mem[slot] <= write_mac;
        end
        if (query_valid) begin
            query_mac <= hit_mac;
        end
    end

    // Full only comes with a done, and only once every slot is taken
    assert property (@(posedge clk) disable iff (rst)
        write_full |-> write_done && (&used));

endmodule

/* project.f */
arp_pkg.sv
arp_cache.sv
arp_static_table.sv
arp_lookup_ctrl.sv
arp_resolver_top.sv
arp_resolver_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the ARP resolver testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module arp_resolver_tb -o arp_resolver_sim

./obj_dir/arp_resolver_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation PASSED"
